// ==== Makefile ====
# Verilator build for the dispatch stage and its testbench

VERILATOR ?= verilator
TOP       ?= tb_dispatch
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing -Wno-fatal
PASS_MSG  := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== credit_counter.sv ====
`timescale 1ns/100ps

module credit_counter #(
	parameter int SLOT_CREDITS = 2
) (
	input  logic clk,
	input  logic rst,
	input  logic take,
	input  logic credit_return,
	output logic has_credit
);

	logic [fu_pkg::CREDIT_W-1:0] count;

	// One credit is one free place in the slot's station
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= fu_pkg::CREDIT_W'(SLOT_CREDITS);
		end else begin
			// A take and a return in the same cycle cancel out
			if (take && !credit_return)
				count <= count - 1'b1;
			else if (credit_return && !take)
				count <= count + 1'b1;
		end
	end

	assign has_credit = (count != '0);

	// The selector must not hand out work the station cannot hold
	assert property (@(posedge clk) disable iff (rst) take |-> has_credit);

	// A slot returning more credits than it was given shows up as overflow
	assert property (@(posedge clk) disable iff (rst)
		count <= fu_pkg::CREDIT_W'(SLOT_CREDITS));

endmodule

// ==== dispatch_select.sv ====
`timescale 1ns/100ps

module dispatch_select #(
	parameter int ROB_ENTRIES = 16,
	localparam int IDX_W = $clog2(ROB_ENTRIES)
) (
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic [ROB_ENTRIES-1:0]                     ent_valid,
	input  logic [ROB_ENTRIES-1:0]                     ent_dispatchable,
	input  logic [ROB_ENTRIES*rob_pkg::FU_CLASS_W-1:0] ent_fu_class,
	input  logic [ROB_ENTRIES-1:0]                     ent_alu0_only,
	input  logic [ROB_ENTRIES-1:0]                     ent_pred,
	input  logic [ROB_ENTRIES*rob_pkg::OPC_W-1:0]      ent_opcode,
	input  logic [ROB_ENTRIES*rob_pkg::PREG_W-1:0]     ent_prs1,
	input  logic [ROB_ENTRIES*rob_pkg::PREG_W-1:0]     ent_prs2,
	input  logic [ROB_ENTRIES*rob_pkg::PREG_W-1:0]     ent_prd,
	input  logic [ROB_ENTRIES*rob_pkg::IMM_W-1:0]      ent_imm,
	input  logic [fu_pkg::NUM_SLOTS-1:0]               has_credit,
	output logic [fu_pkg::NUM_SLOTS-1:0]               take,
	output logic [ROB_ENTRIES-1:0]                     dispatched_mask,
	output logic [fu_pkg::NUM_SLOTS-1:0]               rs_valid,
	output logic [fu_pkg::NUM_SLOTS*IDX_W-1:0]         rs_rndx,
	output logic [fu_pkg::NUM_SLOTS*rob_pkg::OPC_W-1:0]  rs_opcode,
	output logic [fu_pkg::NUM_SLOTS*rob_pkg::PREG_W-1:0] rs_prs1,
	output logic [fu_pkg::NUM_SLOTS*rob_pkg::PREG_W-1:0] rs_prs2,
	output logic [fu_pkg::NUM_SLOTS*rob_pkg::PREG_W-1:0] rs_prd,
	output logic [fu_pkg::NUM_SLOTS*rob_pkg::IMM_W-1:0]  rs_imm
);

	localparam int GS = rob_pkg::GROUP_SIZE;
	localparam int NS = fu_pkg::NUM_SLOTS;
	localparam int WIN_W = $clog2(GS);

	logic [IDX_W-1:0] ptr;
	logic [IDX_W-1:0] grp_idx [GS];
	logic [IDX_W-1:0] win_idx [GS];
	logic [GS-1:0] win_ready;
	logic [rob_pkg::FU_CLASS_W-1:0] win_class [GS];
	logic [GS-1:0] win_alu0;
	logic [GS-1:0] win_pred;
	logic [rob_pkg::OPC_W-1:0] win_opcode [GS];
	logic [rob_pkg::PREG_W-1:0] win_prs1 [GS];
	logic [rob_pkg::PREG_W-1:0] win_prs2 [GS];
	logic [rob_pkg::PREG_W-1:0] win_prd [GS];
	logic [rob_pkg::IMM_W-1:0] win_imm [GS];

	logic [ROB_ENTRIES-1:0] mask_d2;
	logic [ROB_ENTRIES-1:0] recent_mask;
	logic [ROB_ENTRIES-1:0] sel_mask;
	logic [NS-1:0] take_c;
	logic [WIN_W-1:0] slot_win [NS];
	logic placed;

	// ======================================================================
	// Group pointer and window
	// ======================================================================

	always_comb begin
		for (int k = 0; k < GS; k++)
			grp_idx[k] = ptr + IDX_W'(k);
	end

	// The pointer stays on a group that dispatched, else it moves on
	always_ff @(posedge clk) begin
		if (rst) begin
			ptr <= '0;
			win_ready <= '0;
		end else begin
			if (take_c == '0)
				ptr <= (ptr == IDX_W'(ROB_ENTRIES - GS)) ? '0 : ptr + IDX_W'(GS);
			for (int k = 0; k < GS; k++)
				win_ready[k] <= ent_valid[grp_idx[k]] && ent_dispatchable[grp_idx[k]];
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < GS; k++) begin
			win_idx[k] <= grp_idx[k];
			win_class[k] <= ent_fu_class[grp_idx[k]*rob_pkg::FU_CLASS_W +: rob_pkg::FU_CLASS_W];
			win_alu0[k] <= ent_alu0_only[grp_idx[k]];
			win_pred[k] <= ent_pred[grp_idx[k]];
			win_opcode[k] <= ent_opcode[grp_idx[k]*rob_pkg::OPC_W +: rob_pkg::OPC_W];
			win_prs1[k] <= ent_prs1[grp_idx[k]*rob_pkg::PREG_W +: rob_pkg::PREG_W];
			win_prs2[k] <= ent_prs2[grp_idx[k]*rob_pkg::PREG_W +: rob_pkg::PREG_W];
			win_prd[k] <= ent_prd[grp_idx[k]*rob_pkg::PREG_W +: rob_pkg::PREG_W];
			win_imm[k] <= ent_imm[grp_idx[k]*rob_pkg::IMM_W +: rob_pkg::IMM_W];
		end
	end

	// ======================================================================
	// Slot selection
	// ======================================================================

	// The store still shows an entry as valid for two windows after its
	// dispatch, so both earlier decisions are masked out
	assign recent_mask = dispatched_mask | mask_d2;

	always_comb begin
		take_c = '0;
		sel_mask = '0;
		placed = 1'b0;
		for (int s = 0; s < NS; s++)
			slot_win[s] = '0;
		// Older window positions get first pick of the slots
		for (int k = 0; k < GS; k++) begin
			placed = 1'b0;
			if (win_ready[k] && !recent_mask[win_idx[k]]) begin
				for (int s = 0; s < NS; s++) begin
					if (!placed && !take_c[s] && has_credit[s] &&
						fu_pkg::slot_allows(win_class[k], win_alu0[k], s)) begin
						take_c[s] = 1'b1;
						slot_win[s] = WIN_W'(k);
						sel_mask[win_idx[k]] = 1'b1;
						placed = 1'b1;
					end
				end
			end
		end
	end

	assign take = take_c;

	// ======================================================================
	// Registered slot outputs
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			rs_valid <= '0;
			dispatched_mask <= '0;
			mask_d2 <= '0;
		end else begin
			rs_valid <= take_c;
			dispatched_mask <= sel_mask;
			mask_d2 <= dispatched_mask;
		end
	end

	// A predicated-off entry still uses its slot but carries no work
	always_ff @(posedge clk) begin
		for (int s = 0; s < NS; s++) begin
			rs_rndx[s*IDX_W +: IDX_W] <= win_idx[slot_win[s]];
			rs_imm[s*rob_pkg::IMM_W +: rob_pkg::IMM_W] <= win_imm[slot_win[s]];
			if (win_pred[slot_win[s]]) begin
				rs_opcode[s*rob_pkg::OPC_W +: rob_pkg::OPC_W] <= win_opcode[slot_win[s]];
				rs_prs1[s*rob_pkg::PREG_W +: rob_pkg::PREG_W] <= win_prs1[slot_win[s]];
				rs_prs2[s*rob_pkg::PREG_W +: rob_pkg::PREG_W] <= win_prs2[slot_win[s]];
				rs_prd[s*rob_pkg::PREG_W +: rob_pkg::PREG_W] <= win_prd[slot_win[s]];
			end else begin
				rs_opcode[s*rob_pkg::OPC_W +: rob_pkg::OPC_W] <= rob_pkg::OPC_NOP;
				rs_prs1[s*rob_pkg::PREG_W +: rob_pkg::PREG_W] <= '0;
				rs_prs2[s*rob_pkg::PREG_W +: rob_pkg::PREG_W] <= '0;
				rs_prd[s*rob_pkg::PREG_W +: rob_pkg::PREG_W] <= '0;
			end
		end
	end

	// An entry goes out once, so its index cannot reappear on any slot
	// while the two stale windows after its dispatch still show it
	for (genvar a = 0; a < NS; a++) begin : g_rndx_a
		for (genvar b = 0; b < NS; b++) begin : g_rndx_b
			assert property (@(posedge clk) disable iff (rst)
				(rs_valid[b] && $past(rs_valid[a])) |->
				rs_rndx[b*IDX_W +: IDX_W] != $past(rs_rndx[a*IDX_W +: IDX_W]));
			assert property (@(posedge clk) disable iff (rst)
				(rs_valid[b] && $past(rs_valid[a], 2)) |->
				rs_rndx[b*IDX_W +: IDX_W] != $past(rs_rndx[a*IDX_W +: IDX_W], 2));
		end
	end

endmodule

// ==== dispatch_top.sv ====
`timescale 1ns/100ps

module dispatch_top #(
	parameter int ROB_ENTRIES = 16,
	parameter int SLOT_CREDITS = 2,
	localparam int IDX_W = $clog2(ROB_ENTRIES)
) (
	input  logic                                         clk,
	input  logic                                         rst,
	input  logic                                         enq_valid,
	input  logic [rob_pkg::FU_CLASS_W-1:0]               enq_fu_class,
	input  logic                                         enq_alu0_only,
	input  logic                                         enq_pred,
	input  logic [rob_pkg::OPC_W-1:0]                    enq_opcode,
	input  logic [rob_pkg::PREG_W-1:0]                   enq_prs1,
	input  logic [rob_pkg::PREG_W-1:0]                   enq_prs2,
	input  logic [rob_pkg::PREG_W-1:0]                   enq_prd,
	input  logic                                         enq_rs1_ready,
	input  logic                                         enq_rs2_ready,
	input  logic [rob_pkg::IMM_W-1:0]                    enq_imm,
	input  logic                                         wake_valid,
	input  logic [rob_pkg::PREG_W-1:0]                   wake_preg,
	input  logic [fu_pkg::NUM_SLOTS-1:0]                 credit_return,
	output logic                                         enq_credit,
	output logic [fu_pkg::NUM_SLOTS-1:0]                 rs_valid,
	output logic [fu_pkg::NUM_SLOTS*IDX_W-1:0]           rs_rndx,
	output logic [fu_pkg::NUM_SLOTS*rob_pkg::OPC_W-1:0]  rs_opcode,
	output logic [fu_pkg::NUM_SLOTS*rob_pkg::PREG_W-1:0] rs_prs1,
	output logic [fu_pkg::NUM_SLOTS*rob_pkg::PREG_W-1:0] rs_prs2,
	output logic [fu_pkg::NUM_SLOTS*rob_pkg::PREG_W-1:0] rs_prd,
	output logic [fu_pkg::NUM_SLOTS*rob_pkg::IMM_W-1:0]  rs_imm
);

	logic [ROB_ENTRIES-1:0] ent_valid;
	logic [ROB_ENTRIES-1:0] ent_dispatchable;
	logic [ROB_ENTRIES*rob_pkg::FU_CLASS_W-1:0] ent_fu_class;
	logic [ROB_ENTRIES-1:0] ent_alu0_only;
	logic [ROB_ENTRIES-1:0] ent_pred;
	logic [ROB_ENTRIES*rob_pkg::OPC_W-1:0] ent_opcode;
	logic [ROB_ENTRIES*rob_pkg::PREG_W-1:0] ent_prs1;
	logic [ROB_ENTRIES*rob_pkg::PREG_W-1:0] ent_prs2;
	logic [ROB_ENTRIES*rob_pkg::PREG_W-1:0] ent_prd;
	logic [ROB_ENTRIES*rob_pkg::IMM_W-1:0] ent_imm;
	logic [ROB_ENTRIES-1:0] dispatched_mask;
	logic [fu_pkg::NUM_SLOTS-1:0] take;
	logic [fu_pkg::NUM_SLOTS-1:0] has_credit;

	// Groups must tile the store exactly, and a count must fit its counter
	if ((ROB_ENTRIES % rob_pkg::GROUP_SIZE) != 0) begin : g_bad_entries
		$error("ROB_ENTRIES is not a multiple of the group size");
	end
	if (SLOT_CREDITS < 1 || SLOT_CREDITS >= (1 << fu_pkg::CREDIT_W)) begin : g_bad_credits
		$error("SLOT_CREDITS does not fit the credit counter");
	end

	rob_store #(.ROB_ENTRIES(ROB_ENTRIES)) rob_store_i (.*);

	dispatch_select #(.ROB_ENTRIES(ROB_ENTRIES)) dispatch_select_i (.*);

	// One credit counter per functional-unit slot
	for (genvar s = 0; s < fu_pkg::NUM_SLOTS; s++) begin : g_credit
		credit_counter #(.SLOT_CREDITS(SLOT_CREDITS)) credit_counter_i (
			.clk          (clk),
			.rst          (rst),
			.take         (take[s]),
			.credit_return(credit_return[s]),
			.has_credit   (has_credit[s])
		);
	end

endmodule

// ==== fu_pkg.sv ====
package fu_pkg;

	// Number of functional-unit slots fed by the dispatcher
	localparam int NUM_SLOTS = 4;

	// Slot numbers, in the order the selector tries them
	localparam int SLOT_ALU0 = 0;
	localparam int SLOT_ALU1 = 1;
	localparam int SLOT_MUL = 2;
	localparam int SLOT_MEM = 3;

	// Width of a per-slot credit count, so a station holds at most 7
	localparam int CREDIT_W = 3;

	// True when an entry of the given class may go to the given slot.
	// ALU work prefers slot 0 and spills to slot 1 unless it is alu0-only
	function automatic logic slot_allows(
		input logic [rob_pkg::FU_CLASS_W-1:0] fu_class,
		input logic alu0_only,
		input int slot
	);
		logic ok;
		ok = 1'b0;
		case (fu_class)
			rob_pkg::FU_ALU: ok = (slot == SLOT_ALU0) || (slot == SLOT_ALU1 && !alu0_only);
			rob_pkg::FU_MUL: ok = (slot == SLOT_MUL);
			rob_pkg::FU_MEM: ok = (slot == SLOT_MEM);
			default: ok = 1'b0;
		endcase
		return ok;
	endfunction

endpackage

// ==== rob_pkg.sv ====
package rob_pkg;

	// ======================================================================
	// Reorder-buffer entry fields
	// ======================================================================

	// Opcode field of a decoded instruction
	localparam int OPC_W = 8;

	// Physical register number after renaming
	localparam int PREG_W = 6;

	// Immediate carried with the entry
	localparam int IMM_W = 16;

	// ======================================================================
	// Functional-unit classes
	// ======================================================================

	localparam int FU_CLASS_W = 2;

	// Code 3 is left unused and must never be enqueued
	localparam logic [FU_CLASS_W-1:0] FU_ALU = 2'd0;
	localparam logic [FU_CLASS_W-1:0] FU_MUL = 2'd1;
	localparam logic [FU_CLASS_W-1:0] FU_MEM = 2'd2;

	// A predicated-off entry is sent out with this opcode
	localparam logic [OPC_W-1:0] OPC_NOP = 8'h00;

	// The dispatcher looks at this many consecutive entries at once
	localparam int GROUP_SIZE = 4;

endpackage

// ==== rob_store.sv ====
`timescale 1ns/100ps

module rob_store #(
	parameter int ROB_ENTRIES = 16,
	localparam int IDX_W = $clog2(ROB_ENTRIES)
) (
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic                                       enq_valid,
	input  logic [rob_pkg::FU_CLASS_W-1:0]             enq_fu_class,
	input  logic                                       enq_alu0_only,
	input  logic                                       enq_pred,
	input  logic [rob_pkg::OPC_W-1:0]                  enq_opcode,
	input  logic [rob_pkg::PREG_W-1:0]                 enq_prs1,
	input  logic [rob_pkg::PREG_W-1:0]                 enq_prs2,
	input  logic [rob_pkg::PREG_W-1:0]                 enq_prd,
	input  logic                                       enq_rs1_ready,
	input  logic                                       enq_rs2_ready,
	input  logic [rob_pkg::IMM_W-1:0]                  enq_imm,
	input  logic                                       wake_valid,
	input  logic [rob_pkg::PREG_W-1:0]                 wake_preg,
	input  logic [ROB_ENTRIES-1:0]                     dispatched_mask,
	output logic                                       enq_credit,
	output logic [ROB_ENTRIES-1:0]                     ent_valid,
	output logic [ROB_ENTRIES-1:0]                     ent_dispatchable,
	output logic [ROB_ENTRIES*rob_pkg::FU_CLASS_W-1:0] ent_fu_class,
	output logic [ROB_ENTRIES-1:0]                     ent_alu0_only,
	output logic [ROB_ENTRIES-1:0]                     ent_pred,
	output logic [ROB_ENTRIES*rob_pkg::OPC_W-1:0]      ent_opcode,
	output logic [ROB_ENTRIES*rob_pkg::PREG_W-1:0]     ent_prs1,
	output logic [ROB_ENTRIES*rob_pkg::PREG_W-1:0]     ent_prs2,
	output logic [ROB_ENTRIES*rob_pkg::PREG_W-1:0]     ent_prd,
	output logic [ROB_ENTRIES*rob_pkg::IMM_W-1:0]      ent_imm
);

	localparam int PEND_W = $clog2(ROB_ENTRIES + 1);

	logic [ROB_ENTRIES-1:0] valid_q;
	logic [ROB_ENTRIES-1:0] rs1_rdy_q;
	logic [ROB_ENTRIES-1:0] rs2_rdy_q;
	logic [rob_pkg::FU_CLASS_W-1:0] class_q [ROB_ENTRIES];
	logic [ROB_ENTRIES-1:0] alu0_q;
	logic [ROB_ENTRIES-1:0] pred_q;
	logic [rob_pkg::OPC_W-1:0] opcode_q [ROB_ENTRIES];
	logic [rob_pkg::PREG_W-1:0] prs1_q [ROB_ENTRIES];
	logic [rob_pkg::PREG_W-1:0] prs2_q [ROB_ENTRIES];
	logic [rob_pkg::PREG_W-1:0] prd_q [ROB_ENTRIES];
	logic [rob_pkg::IMM_W-1:0] imm_q [ROB_ENTRIES];

	logic [ROB_ENTRIES-1:0] wake1;
	logic [ROB_ENTRIES-1:0] wake2;
	logic [IDX_W-1:0] alloc_idx;
	logic alloc_ok;
	logic [PEND_W-1:0] freed_cnt;
	logic [PEND_W-1:0] pend_q;

	// ======================================================================
	// Allocation and wakeup matching
	// ======================================================================

	always_comb begin
		alloc_idx = '0;
		alloc_ok = 1'b0;
		freed_cnt = '0;
		// Scan from the top so the lowest free entry wins
		for (int i = ROB_ENTRIES - 1; i >= 0; i--) begin
			if (!valid_q[i]) begin
				alloc_idx = IDX_W'(i);
				alloc_ok = 1'b1;
			end
		end
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			wake1[i] = wake_valid && (prs1_q[i] == wake_preg);
			wake2[i] = wake_valid && (prs2_q[i] == wake_preg);
			freed_cnt = freed_cnt + PEND_W'(dispatched_mask[i]);
		end
	end

	// Entry valid bits, and the queue of credits still owed to the producer
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
			pend_q <= '0;
			enq_credit <= 1'b0;
		end else begin
			valid_q <= valid_q & ~dispatched_mask;
			if (enq_valid && alloc_ok)
				valid_q[alloc_idx] <= 1'b1;
			// Several entries can free at once, so credits go back one per cycle
			pend_q <= pend_q + freed_cnt - PEND_W'(pend_q != '0);
			enq_credit <= (pend_q != '0);
		end
	end

	// Payload and source-ready bits only mean something while valid is set
	always_ff @(posedge clk) begin
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			if (valid_q[i] && wake1[i])
				rs1_rdy_q[i] <= 1'b1;
			if (valid_q[i] && wake2[i])
				rs2_rdy_q[i] <= 1'b1;
		end
		if (enq_valid && alloc_ok) begin
			class_q[alloc_idx] <= enq_fu_class;
			alu0_q[alloc_idx] <= enq_alu0_only;
			pred_q[alloc_idx] <= enq_pred;
			opcode_q[alloc_idx] <= enq_opcode;
			prs1_q[alloc_idx] <= enq_prs1;
			prs2_q[alloc_idx] <= enq_prs2;
			prd_q[alloc_idx] <= enq_prd;
			imm_q[alloc_idx] <= enq_imm;
			// A wakeup arriving with the enqueue is not lost
			rs1_rdy_q[alloc_idx] <= enq_rs1_ready || (wake_valid && enq_prs1 == wake_preg);
			rs2_rdy_q[alloc_idx] <= enq_rs2_ready || (wake_valid && enq_prs2 == wake_preg);
		end
	end

	// ======================================================================
	// Flattened view for the selector
	// ======================================================================

	always_comb begin
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			ent_dispatchable[i] = valid_q[i] && (rs1_rdy_q[i] || wake1[i]) &&
				(rs2_rdy_q[i] || wake2[i]);
			ent_fu_class[i*rob_pkg::FU_CLASS_W +: rob_pkg::FU_CLASS_W] = class_q[i];
			ent_opcode[i*rob_pkg::OPC_W +: rob_pkg::OPC_W] = opcode_q[i];
			ent_prs1[i*rob_pkg::PREG_W +: rob_pkg::PREG_W] = prs1_q[i];
			ent_prs2[i*rob_pkg::PREG_W +: rob_pkg::PREG_W] = prs2_q[i];
			ent_prd[i*rob_pkg::PREG_W +: rob_pkg::PREG_W] = prd_q[i];
			ent_imm[i*rob_pkg::IMM_W +: rob_pkg::IMM_W] = imm_q[i];
		end
	end

	assign ent_valid = valid_q;
	assign ent_alu0_only = alu0_q;
	assign ent_pred = pred_q;

	// The producer must stay within its credits, so the store is never full here
	assert property (@(posedge clk) disable iff (rst) enq_valid |-> alloc_ok);

	assert property (@(posedge clk) disable iff (rst) enq_valid |-> enq_fu_class != 2'd3);

	// The selector only dispatches entries that are still held
	assert property (@(posedge clk) disable iff (rst) (dispatched_mask & ~valid_q) == '0);

endmodule

// ==== tb_dispatch.sv ====
`timescale 1ns/100ps

module tb_dispatch;

	localparam int ROB_ENTRIES = 16;
	localparam int SLOT_CREDITS = 2;
	localparam int NS = fu_pkg::NUM_SLOTS;
	localparam int IDX_W = $clog2(ROB_ENTRIES);
	localparam int N_ITEMS = 400;
	localparam int MAX_TAGS = 512;
	localparam int TRAFFIC_LIMIT = 20000;
	localparam int DRAIN_LIMIT = 2000;

	logic clk;
	logic rst;
	logic enq_valid;
	logic [rob_pkg::FU_CLASS_W-1:0] enq_fu_class;
	logic enq_alu0_only;
	logic enq_pred;
	logic [rob_pkg::OPC_W-1:0] enq_opcode;
	logic [rob_pkg::PREG_W-1:0] enq_prs1;
	logic [rob_pkg::PREG_W-1:0] enq_prs2;
	logic [rob_pkg::PREG_W-1:0] enq_prd;
	logic enq_rs1_ready;
	logic enq_rs2_ready;
	logic [rob_pkg::IMM_W-1:0] enq_imm;
	logic wake_valid;
	logic [rob_pkg::PREG_W-1:0] wake_preg;
	logic [NS-1:0] credit_return;
	logic enq_credit;
	logic [NS-1:0] rs_valid;
	logic [NS*IDX_W-1:0] rs_rndx;
	logic [NS*rob_pkg::OPC_W-1:0] rs_opcode;
	logic [NS*rob_pkg::PREG_W-1:0] rs_prs1;
	logic [NS*rob_pkg::PREG_W-1:0] rs_prs2;
	logic [NS*rob_pkg::PREG_W-1:0] rs_prd;
	logic [NS*rob_pkg::IMM_W-1:0] rs_imm;

	// Expected instruction per immediate tag, as the producer sent it
	logic [rob_pkg::FU_CLASS_W-1:0] exp_class [MAX_TAGS];
	logic [rob_pkg::OPC_W-1:0] exp_opcode [MAX_TAGS];
	logic [rob_pkg::PREG_W-1:0] exp_prs1 [MAX_TAGS];
	logic [rob_pkg::PREG_W-1:0] exp_prs2 [MAX_TAGS];
	logic [rob_pkg::PREG_W-1:0] exp_prd [MAX_TAGS];
	logic exp_alu0 [MAX_TAGS];
	logic exp_pred [MAX_TAGS];
	logic exp_rdy1 [MAX_TAGS];
	logic exp_rdy2 [MAX_TAGS];
	int exp_rndx [MAX_TAGS];
	logic woken1 [MAX_TAGS];
	logic woken2 [MAX_TAGS];
	int seen [MAX_TAGS];

	// Store entries in use, and those whose dispatch was just seen on a slot
	logic [ROB_ENTRIES-1:0] occupied;
	logic [ROB_ENTRIES-1:0] freeing;

	// Per-slot results of the last falling-edge sample, checked at the next rising edge
	logic [NS-1:0] chk_v, chk_known, chk_once, chk_slot, chk_data, chk_nop;
	logic [NS-1:0] chk_wake, chk_cap, chk_idx;
	logic started;
	logic final_chk;

	// Slot models hold due cycles of credits in a small ring each
	int ret_due [NS][8];
	int ret_head [NS];
	int ret_cnt [NS];
	int outstanding [NS];

	logic [31:0] rng;
	int cycle, next_tag, prod_credits, missing, errors;
	int n_nop, n_unready, n_alu0, tests_run, tests_failed, err0, wait_cnt;
	bit timed_out;

	dispatch_top #(
		.ROB_ENTRIES (ROB_ENTRIES),
		.SLOT_CREDITS(SLOT_CREDITS)
	) dispatch_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ======================================================================
	// Stimulus helpers
	// ======================================================================

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// The immediate carries a unique tag so each dispatch can be traced back
	task automatic drive_enqueue();
		logic [31:0] a;
		logic [31:0] b;
		int e;
		a = next_rand();
		b = next_rand();
		e = -1;
		// The store writes the instruction into its lowest free entry
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			if (e < 0 && !occupied[i])
				e = i;
		end
		if (e >= 0)
			occupied[e] = 1'b1;
		exp_rndx[next_tag] = e;
		enq_valid = 1'b1;
		enq_fu_class = (a[1:0] == 2'd3) ? rob_pkg::FU_ALU : a[1:0];
		enq_alu0_only = (enq_fu_class == rob_pkg::FU_ALU) && a[2];
		enq_pred = (a[5:3] != 3'd0);
		enq_opcode = a[15:8];
		enq_prs1 = a[21:16];
		enq_prs2 = a[27:22];
		enq_prd = b[5:0];
		enq_rs1_ready = (b[8:6] != 3'd0);
		enq_rs2_ready = (b[11:9] != 3'd0);
		enq_imm = next_tag[rob_pkg::IMM_W-1:0];
		exp_class[next_tag] = enq_fu_class;
		exp_alu0[next_tag] = enq_alu0_only;
		exp_pred[next_tag] = enq_pred;
		exp_opcode[next_tag] = enq_opcode;
		exp_prs1[next_tag] = enq_prs1;
		exp_prs2[next_tag] = enq_prs2;
		exp_prd[next_tag] = enq_prd;
		exp_rdy1[next_tag] = enq_rs1_ready;
		exp_rdy2[next_tag] = enq_rs2_ready;
		if (!enq_pred)
			n_nop++;
		if (!enq_rs1_ready || !enq_rs2_ready)
			n_unready++;
		if (enq_alu0_only)
			n_alu0++;
		prod_credits--;
		started = 1'b1;
		next_tag++;
	endtask

	// Samples one slot's registered output and works out every check flag
	task automatic check_slot(input int s);
		int tag;
		int delay;
		logic [rob_pkg::OPC_W-1:0] op;
		logic [rob_pkg::PREG_W-1:0] r1, r2, rd;
		tag = int'(rs_imm[s*rob_pkg::IMM_W +: rob_pkg::IMM_W]);
		op = rs_opcode[s*rob_pkg::OPC_W +: rob_pkg::OPC_W];
		r1 = rs_prs1[s*rob_pkg::PREG_W +: rob_pkg::PREG_W];
		r2 = rs_prs2[s*rob_pkg::PREG_W +: rob_pkg::PREG_W];
		rd = rs_prd[s*rob_pkg::PREG_W +: rob_pkg::PREG_W];
		chk_v[s] = rs_valid[s];
		if (!rs_valid[s])
			return;
		// Every received item occupies a station place until its credit goes back
		outstanding[s]++;
		chk_cap[s] = (outstanding[s] <= SLOT_CREDITS);
		delay = 1 + int'(next_rand() % 4);
		ret_due[s][(ret_head[s] + ret_cnt[s]) % 8] = cycle + delay;
		ret_cnt[s]++;
		chk_known[s] = (tag < next_tag);
		if (!chk_known[s])
			return;
		chk_once[s] = (seen[tag] == 0);
		seen[tag]++;
		chk_idx[s] = (int'(rs_rndx[s*IDX_W +: IDX_W]) == exp_rndx[tag]);
		if (exp_rndx[tag] >= 0)
			freeing[exp_rndx[tag]] = 1'b1;
		case (exp_class[tag])
			rob_pkg::FU_ALU: chk_slot[s] = (s == fu_pkg::SLOT_ALU0) ||
				(s == fu_pkg::SLOT_ALU1 && !exp_alu0[tag]);
			rob_pkg::FU_MUL: chk_slot[s] = (s == fu_pkg::SLOT_MUL);
			rob_pkg::FU_MEM: chk_slot[s] = (s == fu_pkg::SLOT_MEM);
			default: chk_slot[s] = 1'b0;
		endcase
		chk_data[s] = !exp_pred[tag] || (op == exp_opcode[tag] && r1 == exp_prs1[tag] &&
			r2 == exp_prs2[tag] && rd == exp_prd[tag]);
		chk_nop[s] = exp_pred[tag] || (op == rob_pkg::OPC_NOP && r1 == '0 && r2 == '0 &&
			rd == '0);
		chk_wake[s] = (exp_rdy1[tag] || woken1[tag]) && (exp_rdy2[tag] || woken2[tag]);
	endtask

	// One falling edge: sample outputs, return credits, enqueue and wake
	task automatic step(input bit gen_enq, input bit wake_all);
		logic [31:0] r;
		@(negedge clk);
		cycle++;
		for (int s = 0; s < NS; s++)
			check_slot(s);
		credit_return = '0;
		for (int s = 0; s < NS; s++) begin
			if (ret_cnt[s] > 0 && ret_due[s][ret_head[s]] <= cycle) begin
				credit_return[s] = 1'b1;
				ret_head[s] = (ret_head[s] + 1) % 8;
				ret_cnt[s]--;
				outstanding[s]--;
			end
		end
		if (enq_credit)
			prod_credits++;
		enq_valid = 1'b0;
		r = next_rand();
		if (gen_enq && next_tag < N_ITEMS && prod_credits > 0 && r[1:0] != 2'b00)
			drive_enqueue();
		// A dispatched entry is still held at the coming edge and free after it
		occupied = occupied & ~freeing;
		freeing = '0;
		// Random wakeups during traffic, a sweep of all registers while draining
		wake_valid = wake_all || (gen_enq && r[3:2] != 2'b00);
		wake_preg = wake_all ? cycle[5:0] : r[9:4];
		if (wake_valid) begin
			for (int t = 0; t < next_tag; t++) begin
				if (exp_prs1[t] == wake_preg)
					woken1[t] = 1'b1;
				if (exp_prs2[t] == wake_preg)
					woken2[t] = 1'b1;
			end
		end
	endtask

	function automatic bit slots_idle();
		for (int s = 0; s < NS; s++)
			if (ret_cnt[s] != 0)
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic report_test(input string name, input bit to, input string note);
		bit bad;
		bad = to || (errors != err0);
		tests_run++;
		if (bad)
			tests_failed++;
		$display("Test %0d %s: %s, %0d errors %s", tests_run, name,
			bad ? "failed" : "ok", errors - err0, note);
	endtask

	// ======================================================================
	// Checks
	// ======================================================================

	assert property (@(posedge clk) disable iff (rst) !started |-> rs_valid == '0 && !enq_credit)
	else begin
		errors++;
		$display("[ERROR] %0t: slot output or enqueue credit before any enqueue", $time);
	end

	assert property (@(posedge clk) disable iff (rst)
		final_chk |-> prod_credits == ROB_ENTRIES && missing == 0)
	else begin
		errors++;
		$display("[ERROR] %0t: %0d credits, %0d instructions never dispatched",
			$time, prod_credits, missing);
	end

	for (genvar s = 0; s < NS; s++) begin : g_slot_chk
		assert property (@(posedge clk) disable iff (rst) chk_v[s] |-> chk_known[s] && chk_once[s])
		else begin
			errors++;
			$display("[ERROR] %0t: slot %0d unknown or repeated tag", $time, s);
		end
		assert property (@(posedge clk) disable iff (rst) chk_v[s] |-> chk_slot[s])
		else begin
			errors++;
			$display("[ERROR] %0t: slot %0d not allowed for its class", $time, s);
		end
		assert property (@(posedge clk) disable iff (rst) chk_v[s] |-> chk_data[s])
		else begin
			errors++;
			$display("[ERROR] %0t: slot %0d fields differ from enqueue", $time, s);
		end
		assert property (@(posedge clk) disable iff (rst) chk_v[s] |-> chk_idx[s])
		else begin
			errors++;
			$display("[ERROR] %0t: slot %0d index is not the entry it was written to",
				$time, s);
		end
		assert property (@(posedge clk) disable iff (rst) chk_v[s] |-> chk_nop[s])
		else begin
			errors++;
			$display("[ERROR] %0t: slot %0d predicated-off item not a NOP", $time, s);
		end
		assert property (@(posedge clk) disable iff (rst) chk_v[s] |-> chk_wake[s])
		else begin
			errors++;
			$display("[ERROR] %0t: slot %0d dispatched before its wakeup", $time, s);
		end
		assert property (@(posedge clk) disable iff (rst) chk_v[s] |-> chk_cap[s])
		else begin
			errors++;
			$display("[ERROR] %0t: slot %0d got more items than credits", $time, s);
		end
	end

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		rst = 1'b1;
		enq_valid = 1'b0;
		enq_fu_class = '0;
		enq_alu0_only = 1'b0;
		enq_pred = 1'b0;
		enq_opcode = '0;
		enq_prs1 = '0;
		enq_prs2 = '0;
		enq_prd = '0;
		enq_rs1_ready = 1'b0;
		enq_rs2_ready = 1'b0;
		enq_imm = '0;
		wake_valid = 1'b0;
		wake_preg = '0;
		credit_return = '0;
		rng = 32'h88e5;
		{chk_v, chk_known, chk_once, chk_slot, chk_data, chk_nop, chk_wake, chk_cap} = '0;
		chk_idx = '0;
		occupied = '0;
		freeing = '0;
		started = 1'b0;
		final_chk = 1'b0;
		prod_credits = ROB_ENTRIES;
		for (int s = 0; s < NS; s++) begin
			ret_head[s] = 0;
			ret_cnt[s] = 0;
			outstanding[s] = 0;
		end
		for (int t = 0; t < MAX_TAGS; t++) begin
			seen[t] = 0;
			woken1[t] = 1'b0;
			woken2[t] = 1'b0;
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Idle after reset, nothing may come out of either end
		err0 = errors;
		repeat (10)
			step(1'b0, 1'b0);
		report_test("reset idle", 1'b0, "");

		// Random instructions under credit limits on both sides
		err0 = errors;
		wait_cnt = 0;
		while (next_tag < N_ITEMS && wait_cnt < TRAFFIC_LIMIT) begin
			step(1'b1, 1'b0);
			wait_cnt++;
		end
		if (next_tag < N_ITEMS) begin
			timed_out = 1'b1;
			$display("Timeout: producer got stuck after %0d instructions", next_tag);
		end
		report_test("random traffic", next_tag < N_ITEMS,
			$sformatf("(%0d NOP, %0d unready, %0d alu0-only)", n_nop, n_unready, n_alu0));

		// Wake everything and wait for every credit to come home
		err0 = errors;
		wait_cnt = 0;
		while ((prod_credits != ROB_ENTRIES || !slots_idle()) && wait_cnt < DRAIN_LIMIT) begin
			step(1'b0, 1'b1);
			wait_cnt++;
		end
		if (wait_cnt >= DRAIN_LIMIT) begin
			timed_out = 1'b1;
			$display("Timeout: store did not drain, producer holds %0d credits", prod_credits);
		end
		missing = 0;
		for (int t = 0; t < next_tag; t++)
			if (seen[t] == 0)
				missing++;
		final_chk = 1'b1;
		step(1'b0, 1'b0);
		final_chk = 1'b0;
		report_test("drain", wait_cnt >= DRAIN_LIMIT, "");

		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== vlog.f ====
rob_pkg.sv
fu_pkg.sv
credit_counter.sv
rob_store.sv
dispatch_select.sv
dispatch_top.sv
tb_dispatch.sv
